/* logic/axil_pkg.sv */
/* AXI4-Lite bus definitions shared by the memory slave
   Widths, word types and the response codes in use */

`default_nettype none

package axil_pkg;

  // ----------------------------------------------------------------------
  // Bus widths
  // ----------------------------------------------------------------------
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int STRB_W = DATA_W / 8;          // One strobe bit per byte lane

  typedef logic [ADDR_W-1:0] axil_addr_t;
  typedef logic [DATA_W-1:0] axil_data_t;
  typedef logic [STRB_W-1:0] axil_strb_t;

  // ----------------------------------------------------------------------
  // Response codes
  // ----------------------------------------------------------------------
  typedef logic [1:0] axil_resp_t;

  localparam axil_resp_t RESP_OKAY   = 2'b00;
  localparam axil_resp_t RESP_SLVERR = 2'b10;  // Address outside the memory

endpackage

`default_nettype wire

/* logic/dram_map_pkg.sv */
/* Memory organisation of the banked simulation SRAM
   Bank count, bank depth and the byte address split */

`default_nettype none

package dram_map_pkg;

  localparam int BANKS_DEF  = 4;               // Word interleaved banks
  localparam int ROWS_DEF   = 256;             // Words per bank
  localparam int RST_CYCLES = 64;              // Memory reset hold time

  localparam int OFFS_W  = 2;
  localparam int BANK_W  = $clog2(BANKS_DEF);
  localparam int ROW_W   = $clog2(ROWS_DEF);
  localparam int UPPER_W = axil_pkg::ADDR_W - ROW_W - BANK_W - OFFS_W;

  typedef logic [BANK_W-1:0] bank_idx_t;
  typedef logic [ROW_W-1:0]  row_idx_t;

  typedef struct packed {
    logic [UPPER_W-1:0] upper;                 // Must be zero for a hit
    row_idx_t           row;
    bank_idx_t          bank;
    logic [OFFS_W-1:0]  offset;
  } dram_fields_t;

  // Same address word, as a raw byte address or split into fields
  typedef union packed {
    axil_pkg::axil_addr_t raw;
    dram_fields_t         f;
  } dram_addr_u;

endpackage

`default_nettype wire

/* logic/rst_seq.sv */
/* Memory reset sequencer, holds the memory side in reset until
   the hold counter has expired and the clock generator is locked */

`default_nettype none

module rst_seq (
  input  logic mig_ui_clk,
  input  logic mig_ui_rst,
  input  logic pll_locked_i,
  output logic mem_rst_n_o
);
  import dram_map_pkg::*;

  localparam int CNT_W = $clog2(RST_CYCLES + 1);

  logic [CNT_W-1:0] cnt_q;
  logic             cnt_done;
  logic             mem_rst_n_q;

  assign cnt_done = (cnt_q == CNT_W'(RST_CYCLES));

  always_ff @(posedge mig_ui_clk or posedge mig_ui_rst)
  begin
    if (mig_ui_rst)
    begin
      cnt_q       <= '0;
      mem_rst_n_q <= 1'b0;
    end
    else
    begin
      if (!cnt_done)
        cnt_q <= cnt_q + 1'b1;                 // Saturates at RST_CYCLES
      if (cnt_done && pll_locked_i)
        mem_rst_n_q <= 1'b1;                   // Sticky until next reset
    end
  end

  assign mem_rst_n_o = mem_rst_n_q;

endmodule

`default_nettype wire

/* logic/axil_mem_frontend.sv */
/* AXI4-Lite front end of the banked memory, decodes addresses,
   issues one bank access per cycle and returns write responses */

`default_nettype none

module axil_mem_frontend #(
  parameter int NUM_BANKS = dram_map_pkg::BANKS_DEF,
  parameter int BANK_ROWS = dram_map_pkg::ROWS_DEF
) (
  input  logic                   mig_ui_clk,
  input  logic                   mig_ui_rst,
  input  logic                   mem_rst_n_i,
  input  logic                   awvalid_i,
  input  axil_pkg::axil_addr_t   awaddr_i,
  input  logic                   wvalid_i,
  input  axil_pkg::axil_data_t   wdata_i,
  input  axil_pkg::axil_strb_t   wstrb_i,
  input  logic                   bready_i,
  input  logic                   arvalid_i,
  input  axil_pkg::axil_addr_t   araddr_i,
  input  logic                   rd_space_i,
  output logic                   awready_o,
  output logic                   wready_o,
  output logic                   bvalid_o,
  output axil_pkg::axil_resp_t   bresp_o,
  output logic                   arready_o,
  output logic [NUM_BANKS-1:0]   bank_req_o,
  output logic                   bank_we_o,
  output dram_map_pkg::row_idx_t bank_row_o,
  output axil_pkg::axil_data_t   bank_wdata_o,
  output axil_pkg::axil_strb_t   bank_be_o,
  output logic                   rd_push_o,
  output dram_map_pkg::bank_idx_t rd_bank_o,
  output logic                   rd_err_o
);
  import axil_pkg::*;
  import dram_map_pkg::*;

  localparam int BANK_LSB = $clog2(STRB_W);
  localparam int ROW_LSB  = BANK_LSB + $clog2(NUM_BANKS);
  localparam int TOP_LSB  = ROW_LSB + $clog2(BANK_ROWS);

  dram_addr_u aw_u;
  dram_addr_u ar_u;
  bank_idx_t  aw_bank;
  bank_idx_t  ar_bank;
  row_idx_t   aw_row;
  row_idx_t   ar_row;
  logic       aw_oor;
  logic       ar_oor;
  logic       wr_go;
  logic       rd_go;
  logic       bvalid_q;
  axil_resp_t bresp_q;

  assign aw_u.raw = awaddr_i;
  assign ar_u.raw = araddr_i;

  // ----------------------------------------------------------------------
  // Address decode
  // ----------------------------------------------------------------------
  if (NUM_BANKS == BANKS_DEF && BANK_ROWS == ROWS_DEF)
  begin : g_def_map
    assign aw_bank = aw_u.f.bank;
    assign aw_row  = aw_u.f.row;
    assign aw_oor  = |aw_u.f.upper;
    assign ar_bank = ar_u.f.bank;
    assign ar_row  = ar_u.f.row;
    assign ar_oor  = |ar_u.f.upper;
  end
  else
  begin : g_par_map
    // Field boundaries follow the module parameters
    assign aw_bank = bank_idx_t'(aw_u.raw[ROW_LSB-1:BANK_LSB]);
    assign aw_row  = row_idx_t'(aw_u.raw[TOP_LSB-1:ROW_LSB]);
    assign aw_oor  = |aw_u.raw[ADDR_W-1:TOP_LSB];
    assign ar_bank = bank_idx_t'(ar_u.raw[ROW_LSB-1:BANK_LSB]);
    assign ar_row  = row_idx_t'(ar_u.raw[TOP_LSB-1:ROW_LSB]);
    assign ar_oor  = |ar_u.raw[ADDR_W-1:TOP_LSB];
  end

  // ----------------------------------------------------------------------
  // Arbitration, write wins over read
  // ----------------------------------------------------------------------
  assign wr_go     = mem_rst_n_i && awvalid_i && wvalid_i && !bvalid_q;
  assign awready_o = wr_go;                    // AW and W taken together
  assign wready_o  = wr_go;
  assign arready_o = mem_rst_n_i && rd_space_i && !wr_go;
  assign rd_go     = arready_o && arvalid_i;

  always_comb
  begin
    bank_req_o = '0;
    if (wr_go && !aw_oor)
      bank_req_o[aw_bank] = 1'b1;
    else if (rd_go && !ar_oor)
      bank_req_o[ar_bank] = 1'b1;
  end

  assign bank_we_o    = wr_go;
  assign bank_row_o   = wr_go ? aw_row : ar_row;
  assign bank_wdata_o = wdata_i;
  assign bank_be_o    = wstrb_i;

  assign rd_push_o = rd_go;                    // Misses still return a beat
  assign rd_bank_o = ar_bank;
  assign rd_err_o  = ar_oor;

  // ----------------------------------------------------------------------
  // Write response
  // ----------------------------------------------------------------------
  always_ff @(posedge mig_ui_clk or posedge mig_ui_rst)
  begin
    if (mig_ui_rst)
      bvalid_q <= 1'b0;
    else if (wr_go)
      bvalid_q <= 1'b1;
    else if (bready_i)
      bvalid_q <= 1'b0;
  end

  always_ff @(posedge mig_ui_clk)
  begin
    if (wr_go)
      bresp_q <= aw_oor ? RESP_SLVERR : RESP_OKAY;
  end

  assign bvalid_o = bvalid_q;
  assign bresp_o  = bresp_q;

endmodule

`default_nettype wire

/* logic/sram_bank.sv */
/* One word-wide SRAM bank with byte write enables
   and a registered read port */

`default_nettype none

module sram_bank #(
  parameter int BANK_ROWS = dram_map_pkg::ROWS_DEF
) (
  input  logic                   mig_ui_clk,
  input  logic                   req_i,
  input  logic                   we_i,
  input  dram_map_pkg::row_idx_t row_i,
  input  axil_pkg::axil_data_t   wdata_i,
  input  axil_pkg::axil_strb_t   be_i,
  output axil_pkg::axil_data_t   rdata_o
);
  import axil_pkg::*;

  axil_data_t mem_q [BANK_ROWS];
  axil_data_t rdata_q;

  always_ff @(posedge mig_ui_clk)
  begin
    if (req_i)
    begin
      if (we_i)
      begin
        for (int b = 0; b < STRB_W; b++)
        begin
          if (be_i[b])
            mem_q[row_i][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
      else
        rdata_q <= mem_q[row_i];               // Held until the next read
    end
  end

  assign rdata_o = rdata_q;

endmodule

`default_nettype wire

/* logic/rd_collect.sv */
/* Read return path, picks the addressed bank's data and queues up
   to two beats in order for the R channel */

`default_nettype none

module rd_collect #(
  parameter int NUM_BANKS = dram_map_pkg::BANKS_DEF
) (
  input  logic                    mig_ui_clk,
  input  logic                    mig_ui_rst,
  input  logic                    mem_rst_n_i,
  input  logic                    rd_push_i,
  input  dram_map_pkg::bank_idx_t rd_bank_i,
  input  logic                    rd_err_i,
  input  axil_pkg::axil_data_t    bank_rdata_i [NUM_BANKS],
  input  logic                    rready_i,
  output logic                    rd_space_o,
  output logic                    rvalid_o,
  output axil_pkg::axil_data_t    rdata_o,
  output axil_pkg::axil_resp_t    rresp_o
);
  import axil_pkg::*;
  import dram_map_pkg::*;

  logic       cap_vld_q;
  bank_idx_t  cap_bank_q;
  logic       cap_err_q;
  axil_data_t cap_data;
  axil_data_t q_data [2];
  axil_resp_t q_resp [2];
  logic       wr_ptr_q;
  logic       rd_ptr_q;
  logic [1:0] q_cnt_q;
  logic [1:0] out_q;
  logic       pop;

  assign pop      = rvalid_o && rready_i;
  assign cap_data = cap_err_q ? '0 : bank_rdata_i[cap_bank_q];

  // ----------------------------------------------------------------------
  // Queue and outstanding read control
  // ----------------------------------------------------------------------
  always_ff @(posedge mig_ui_clk or posedge mig_ui_rst)
  begin
    if (mig_ui_rst)
    begin
      cap_vld_q <= 1'b0;
      wr_ptr_q  <= 1'b0;
      rd_ptr_q  <= 1'b0;
      q_cnt_q   <= '0;
      out_q     <= '0;
    end
    else
    begin
      cap_vld_q <= rd_push_i;                  // Bank data ready next cycle
      if (cap_vld_q)
        wr_ptr_q <= ~wr_ptr_q;
      if (pop)
        rd_ptr_q <= ~rd_ptr_q;
      q_cnt_q <= q_cnt_q + 2'(cap_vld_q) - 2'(pop);
      out_q   <= out_q + 2'(rd_push_i) - 2'(pop); // Issued but not yet returned
    end
  end

  always_ff @(posedge mig_ui_clk)
  begin
    if (rd_push_i)
    begin
      cap_bank_q <= rd_bank_i;
      cap_err_q  <= rd_err_i;
    end
    if (cap_vld_q)
    begin
      q_data[wr_ptr_q] <= cap_data;
      q_resp[wr_ptr_q] <= cap_err_q ? RESP_SLVERR : RESP_OKAY;
    end
  end

  assign rd_space_o = mem_rst_n_i && (out_q < 2'd2);
  assign rvalid_o   = (q_cnt_q != 2'd0);
  assign rdata_o    = q_data[rd_ptr_q];        // Queue head
  assign rresp_o    = q_resp[rd_ptr_q];

endmodule

`default_nettype wire

/* logic/mem_subsys_top.sv */
/* Simulation memory subsystem, reset sequencer plus an AXI4-Lite
   slave over word interleaved SRAM banks */

`default_nettype none

module mem_subsys_top #(
  parameter int NUM_BANKS = dram_map_pkg::BANKS_DEF,
  parameter int BANK_ROWS = dram_map_pkg::ROWS_DEF
) (
  input  logic                 mig_ui_clk,
  input  logic                 mig_ui_rst,
  input  logic                 pll_locked_i,
  output logic                 mem_ready_o,
  input  logic                 awvalid_i,
  output logic                 awready_o,
  input  axil_pkg::axil_addr_t awaddr_i,
  input  logic                 wvalid_i,
  output logic                 wready_o,
  input  axil_pkg::axil_data_t wdata_i,
  input  axil_pkg::axil_strb_t wstrb_i,
  output logic                 bvalid_o,
  input  logic                 bready_i,
  output axil_pkg::axil_resp_t bresp_o,
  input  logic                 arvalid_i,
  output logic                 arready_o,
  input  axil_pkg::axil_addr_t araddr_i,
  output logic                 rvalid_o,
  input  logic                 rready_i,
  output axil_pkg::axil_data_t rdata_o,
  output axil_pkg::axil_resp_t rresp_o
);
  import axil_pkg::*;
  import dram_map_pkg::*;

  logic                 mem_rst_n;
  logic [NUM_BANKS-1:0] bank_req;
  logic                 bank_we;
  row_idx_t             bank_row;
  axil_data_t           bank_wdata;
  axil_strb_t           bank_be;
  axil_data_t           bank_rdata [NUM_BANKS];
  logic                 rd_push;
  bank_idx_t            rd_bank;
  logic                 rd_err;
  logic                 rd_space;

  rst_seq rst_seq_inst (
    .mig_ui_clk   ( mig_ui_clk   ),
    .mig_ui_rst   ( mig_ui_rst   ),
    .pll_locked_i ( pll_locked_i ),
    .mem_rst_n_o  ( mem_rst_n    )
  );

  assign mem_ready_o = mem_rst_n;

  axil_mem_frontend #(
    .NUM_BANKS ( NUM_BANKS ),
    .BANK_ROWS ( BANK_ROWS )
  ) axil_mem_frontend_inst (
    .mig_ui_clk   ( mig_ui_clk ),
    .mig_ui_rst   ( mig_ui_rst ),
    .mem_rst_n_i  ( mem_rst_n  ),
    .awvalid_i    ( awvalid_i  ),
    .awaddr_i     ( awaddr_i   ),
    .wvalid_i     ( wvalid_i   ),
    .wdata_i      ( wdata_i    ),
    .wstrb_i      ( wstrb_i    ),
    .bready_i     ( bready_i   ),
    .arvalid_i    ( arvalid_i  ),
    .araddr_i     ( araddr_i   ),
    .rd_space_i   ( rd_space   ),
    .awready_o    ( awready_o  ),
    .wready_o     ( wready_o   ),
    .bvalid_o     ( bvalid_o   ),
    .bresp_o      ( bresp_o    ),
    .arready_o    ( arready_o  ),
    .bank_req_o   ( bank_req   ),
    .bank_we_o    ( bank_we    ),
    .bank_row_o   ( bank_row   ),
    .bank_wdata_o ( bank_wdata ),
    .bank_be_o    ( bank_be    ),
    .rd_push_o    ( rd_push    ),
    .rd_bank_o    ( rd_bank    ),
    .rd_err_o     ( rd_err     )
  );

  // ----------------------------------------------------------------------
  // Word interleaved banks
  // ----------------------------------------------------------------------
  for (genvar g = 0; g < NUM_BANKS; g++)
  begin : g_bank
    sram_bank #(
      .BANK_ROWS ( BANK_ROWS )
    ) sram_bank_inst (
      .mig_ui_clk ( mig_ui_clk    ),
      .req_i      ( bank_req[g]   ),
      .we_i       ( bank_we       ),
      .row_i      ( bank_row      ),
      .wdata_i    ( bank_wdata    ),
      .be_i       ( bank_be       ),
      .rdata_o    ( bank_rdata[g] )
    );
  end

  rd_collect #(
    .NUM_BANKS ( NUM_BANKS )
  ) rd_collect_inst (
    .mig_ui_clk   ( mig_ui_clk ),
    .mig_ui_rst   ( mig_ui_rst ),
    .mem_rst_n_i  ( mem_rst_n  ),
    .rd_push_i    ( rd_push    ),
    .rd_bank_i    ( rd_bank    ),
    .rd_err_i     ( rd_err     ),
    .bank_rdata_i ( bank_rdata ),
    .rready_i     ( rready_i   ),
    .rd_space_o   ( rd_space   ),
    .rvalid_o     ( rvalid_o   ),
    .rdata_o      ( rdata_o    ),
    .rresp_o      ( rresp_o    )
  );

endmodule

`default_nettype wire

/* verification/mem_subsys_chk.sv */
/* Bus protocol assertions for the banked memory subsystem,
   bound onto the top level */

`default_nettype none

module mem_subsys_chk (
  input  logic                 mig_ui_clk,
  input  logic                 mig_ui_rst,
  input  logic                 mem_ready_i,
  input  logic                 awready_i,
  input  logic                 wready_i,
  input  logic                 arready_i,
  input  logic                 bvalid_i,
  input  logic                 bready_i,
  input  axil_pkg::axil_resp_t bresp_i,
  input  logic                 rvalid_i,
  input  logic                 rready_i,
  input  axil_pkg::axil_data_t rdata_i
);

  // B channel holds until taken
  b_hold_a : assert property (@(posedge mig_ui_clk) disable iff (mig_ui_rst)
    bvalid_i && !bready_i |=> bvalid_i && $stable(bresp_i))
    else $error("B response changed or dropped before bready");

  // R channel holds until taken
  r_hold_a : assert property (@(posedge mig_ui_clk) disable iff (mig_ui_rst)
    rvalid_i && !rready_i |=> rvalid_i && $stable(rdata_i))
    else $error("R beat changed or dropped before rready");

  no_ready_a : assert property (@(posedge mig_ui_clk)
    !mem_ready_i |-> !(awready_i || wready_i || arready_i))
    else $error("Ready output high while memory held in reset");

endmodule

`default_nettype wire

/* verification/mem_subsys_tb.sv */
/* Directed testbench for the banked AXI4-Lite memory subsystem
   with a reference word model and bound protocol assertions */

`default_nettype none

module mem_subsys_tb;
  import axil_pkg::*;
  import dram_map_pkg::*;

  localparam int MEM_WORDS  = BANKS_DEF * ROWS_DEF;
  localparam int MAX_CYCLES = 2000;            // About 600 used by the tests

  logic       mig_ui_clk;
  logic       mig_ui_rst;
  logic       pll_locked_i;
  logic       mem_ready_o;
  logic       awvalid_i;
  logic       awready_o;
  axil_addr_t awaddr_i;
  logic       wvalid_i;
  logic       wready_o;
  axil_data_t wdata_i;
  axil_strb_t wstrb_i;
  logic       bvalid_o;
  logic       bready_i;
  axil_resp_t bresp_o;
  logic       arvalid_i;
  logic       arready_o;
  axil_addr_t araddr_i;
  logic       rvalid_o;
  logic       rready_i;
  axil_data_t rdata_o;
  axil_resp_t rresp_o;

  axil_data_t exp_mem [MEM_WORDS];             // Reference memory contents
  axil_data_t got_data [4];
  axil_resp_t got_resp [4];
  int         cycle_cnt;
  int         data_errs;
  int         resp_errs;
  int         ready_errs;
  int         other_errs;

  mem_subsys_top #(
    .NUM_BANKS ( BANKS_DEF ),
    .BANK_ROWS ( ROWS_DEF  )
  ) mem_subsys_top_inst (.*);

  bind mem_subsys_top mem_subsys_chk mem_subsys_chk_inst (
    .mig_ui_clk  ( mig_ui_clk  ),
    .mig_ui_rst  ( mig_ui_rst  ),
    .mem_ready_i ( mem_ready_o ),
    .awready_i   ( awready_o   ),
    .wready_i    ( wready_o    ),
    .arready_i   ( arready_o   ),
    .bvalid_i    ( bvalid_o    ),
    .bready_i    ( bready_i    ),
    .bresp_i     ( bresp_o     ),
    .rvalid_i    ( rvalid_o    ),
    .rready_i    ( rready_i    ),
    .rdata_i     ( rdata_o     )
  );

  initial mig_ui_clk = 1'b0;
  always #10 mig_ui_clk = ~mig_ui_clk;

  always @(posedge mig_ui_clk)
  begin
    cycle_cnt++;
    if (cycle_cnt >= MAX_CYCLES)
    begin
      $display("Timeout: tests did not finish within %0d cycles", MAX_CYCLES);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  // ----------------------------------------------------------------------
  // Compare tasks and reference model
  // ----------------------------------------------------------------------
  task automatic check_data(input string name, input axil_data_t act, input axil_data_t exp);
    if (act !== exp)
    begin
      $display("Error at %0t: %s = %h, expected %h", $time, name, act, exp);
      data_errs++;
    end
  endtask

  task automatic check_resp(input string name, input axil_resp_t act, input axil_resp_t exp);
    if (act !== exp)
    begin
      $display("Error at %0t: %s = %b, expected %b", $time, name, act, exp);
      resp_errs++;
    end
  endtask

  task automatic check_ready(input string name, input logic act, input logic exp);
    if (act !== exp)
    begin
      $display("Error at %0t: %s = %b, expected %b", $time, name, act, exp);
      ready_errs++;
    end
  endtask

  function automatic logic in_range(input axil_addr_t addr);
    return addr < axil_addr_t'(MEM_WORDS * STRB_W);
  endfunction

  function automatic axil_data_t exp_rdata(input axil_addr_t addr);
    return in_range(addr) ? exp_mem[int'(addr >> 2)] : '0;
  endfunction

  function automatic axil_resp_t exp_resp(input axil_addr_t addr);
    return in_range(addr) ? RESP_OKAY : RESP_SLVERR;
  endfunction

  task automatic model_write(input axil_addr_t addr, input axil_data_t data,
                             input axil_strb_t strb);
    if (in_range(addr))
    begin
      for (int b = 0; b < STRB_W; b++)
      begin
        if (strb[b])
          exp_mem[int'(addr >> 2)][8*b +: 8] = data[8*b +: 8];
      end
    end
  endtask

  // ----------------------------------------------------------------------
  // Bus master tasks start and end 2 units after a rising edge
  // ----------------------------------------------------------------------
  task automatic send_write(input axil_addr_t addr, input axil_data_t data,
                            input axil_strb_t strb);
    awvalid_i = 1'b1;
    awaddr_i  = addr;
    wvalid_i  = 1'b1;
    wdata_i   = data;
    wstrb_i   = strb;
    @(negedge mig_ui_clk);
    while (!(awready_o && wready_o))
      @(negedge mig_ui_clk);
    @(posedge mig_ui_clk);
    #2;
    awvalid_i = 1'b0;
    wvalid_i  = 1'b0;
    model_write(addr, data, strb);
  endtask

  task automatic take_b(input axil_resp_t exp);
    bready_i = 1'b1;
    @(negedge mig_ui_clk);
    while (!bvalid_o)
      @(negedge mig_ui_clk);
    check_resp("bresp_o", bresp_o, exp);
    @(posedge mig_ui_clk);
    #2;
    bready_i = 1'b0;
  endtask

  task automatic do_write(input axil_addr_t addr, input axil_data_t data,
                          input axil_strb_t strb);
    send_write(addr, data, strb);
    take_b(exp_resp(addr));
  endtask

  task automatic send_ar(input axil_addr_t addr);
    arvalid_i = 1'b1;
    araddr_i  = addr;
    @(negedge mig_ui_clk);
    while (!arready_o)
      @(negedge mig_ui_clk);
    @(posedge mig_ui_clk);
    #2;
    arvalid_i = 1'b0;
  endtask

  task automatic collect_reads(input int n);
    rready_i = 1'b1;
    for (int i = 0; i < n; i++)
    begin
      @(negedge mig_ui_clk);
      while (!rvalid_o)
        @(negedge mig_ui_clk);
      got_data[i] = rdata_o;
      got_resp[i] = rresp_o;
      @(posedge mig_ui_clk);                   // Beat taken here
    end
    #2;
    rready_i = 1'b0;
  endtask

  task automatic do_read(input axil_addr_t addr);
    send_ar(addr);
    collect_reads(1);
    check_data("rdata_o", got_data[0], exp_rdata(addr));
    check_resp("rresp_o", got_resp[0], exp_resp(addr));
  endtask

  // ----------------------------------------------------------------------
  // Directed tests
  // ----------------------------------------------------------------------
  task automatic test_reset_release();
    int   waited;
    logic seen;
    repeat (200)
    begin
      @(negedge mig_ui_clk);
      check_ready("mem_ready_o", mem_ready_o, 1'b0);
      check_ready("arready_o", arready_o, 1'b0);
    end
    @(posedge mig_ui_clk);
    #2;
    pll_locked_i = 1'b1;
    seen   = 1'b0;
    waited = 0;
    while (!seen && waited < RST_CYCLES + 2)
    begin
      @(negedge mig_ui_clk);
      seen = mem_ready_o;
      waited++;
    end
    if (!seen)
    begin
      $display("mem_ready_o did not rise within %0d cycles of lock", RST_CYCLES + 2);
      other_errs++;
    end
    check_ready("arready_o", arready_o, 1'b1);
    @(posedge mig_ui_clk);
    #2;
  endtask

  task automatic test_all_banks();
    for (int i = 0; i < 16; i++)
      do_write(32'h100 + 4 * i, $urandom, '1);
    for (int i = 0; i < 16; i++)
      do_read(32'h100 + 4 * i);
  endtask

  task automatic test_strobes();
    do_write(32'h200, 32'h1122_3344, '1);
    for (int b = 0; b < STRB_W; b++)
    begin
      do_write(32'h200, $urandom, axil_strb_t'(1 << b));
      do_read(32'h200);
    end
  endtask

  task automatic test_out_of_range();
    do_write(32'h340, 32'hA5A5_0F0F, '1);
    do_write(32'h0040_0340, 32'h5A5A_F0F0, '1); // Aliases row and bank of 0x340
    do_read(32'h0040_0340);
    do_read(32'h340);
  endtask

  task automatic test_read_backpressure();
    for (int i = 0; i < 3; i++)
      do_write(32'h400 + 4 * i, $urandom, '1);
    send_ar(32'h400);
    send_ar(32'h404);
    arvalid_i = 1'b1;                          // Third read must stall
    araddr_i  = 32'h408;
    repeat (3)
    begin
      @(negedge mig_ui_clk);
      check_ready("arready_o", arready_o, 1'b0);
      check_ready("rvalid_o", rvalid_o, 1'b1);
    end
    @(posedge mig_ui_clk);
    #2;
    fork
      send_ar(32'h408);
      collect_reads(3);
    join
    for (int i = 0; i < 3; i++)
    begin
      check_data("rdata_o", got_data[i], exp_rdata(32'h400 + 4 * i));
      check_resp("rresp_o", got_resp[i], RESP_OKAY);
    end
  endtask

  task automatic test_b_backpressure();
    axil_data_t d2;
    d2 = $urandom;
    send_write(32'h500, $urandom, '1);
    awvalid_i = 1'b1;                          // Second write held off by B
    awaddr_i  = 32'h504;
    wvalid_i  = 1'b1;
    wdata_i   = d2;
    wstrb_i   = '1;
    repeat (3)
    begin
      @(negedge mig_ui_clk);
      check_ready("awready_o", awready_o, 1'b0);
      check_ready("wready_o", wready_o, 1'b0);
      check_ready("bvalid_o", bvalid_o, 1'b1);
    end
    @(posedge mig_ui_clk);
    #2;
    take_b(RESP_OKAY);
    send_write(32'h504, d2, '1);
    take_b(RESP_OKAY);
    do_read(32'h500);
    do_read(32'h504);
  endtask

  initial
  begin
    void'($urandom(1859));
    cycle_cnt    = 0;
    data_errs    = 0;
    resp_errs    = 0;
    ready_errs   = 0;
    other_errs   = 0;
    mig_ui_rst   = 1'b1;
    pll_locked_i = 1'b0;
    awvalid_i    = 1'b0;
    awaddr_i     = '0;
    wvalid_i     = 1'b0;
    wdata_i      = '0;
    wstrb_i      = '0;
    bready_i     = 1'b0;
    arvalid_i    = 1'b0;
    araddr_i     = '0;
    rready_i     = 1'b0;
    repeat (2) @(posedge mig_ui_clk);
    #2;
    mig_ui_rst = 1'b0;

    test_reset_release();
    test_all_banks();
    test_strobes();
    test_out_of_range();
    test_read_backpressure();
    test_b_backpressure();

    $display("Errors: data %0d, response %0d, ready %0d, other %0d",
             data_errs, resp_errs, ready_errs, other_errs);
    if (data_errs + resp_errs + ready_errs + other_errs == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
logic/axil_pkg.sv
logic/dram_map_pkg.sv
logic/rst_seq.sv
logic/axil_mem_frontend.sv
logic/sram_bank.sv
logic/rd_collect.sv
logic/mem_subsys_top.sv
verification/mem_subsys_chk.sv
verification/mem_subsys_tb.sv

/* Bender.yml */
package:
  name: mem_subsys

sources:
  # Packages first, then the RTL in dependency order
  - files:
      - logic/axil_pkg.sv
      - logic/dram_map_pkg.sv
      - logic/rst_seq.sv
      - logic/axil_mem_frontend.sv
      - logic/sram_bank.sv
      - logic/rd_collect.sv
      - logic/mem_subsys_top.sv

  # Testbench and bound assertions
  - target: simulation
    files:
      - verification/mem_subsys_chk.sv
      - verification/mem_subsys_tb.sv
